//--- include/tcdm_fifo_defines.svh
// --------------------
// width and depth macros for the tcdm decoupling queue
// --------------------

`ifndef TCDM_FIFO_DEFINES_SVH
`define TCDM_FIFO_DEFINES_SVH

// address bus width in bits
`define TCDM_AW 32

// read and write data width in bits
`define TCDM_DW 32

// one byte enable per data byte
`define TCDM_BW (`TCDM_DW / 8)

// words held by each of the two stream fifos
// request fifo and response fifo use the same depth
`define TCDM_FIFO_DEPTH 8

`endif // TCDM_FIFO_DEFINES_SVH

//--- verilog/tcdm_fifo_pkg.sv
// --------------------
// request and response structs and the operation enum
// --------------------

`include "tcdm_fifo_defines.svh"

package tcdm_fifo_pkg;

  // operation carried with every request
  // encoded like the classic wen bit so 1 means read
  typedef enum logic {
    OP_WRITE = 1'b0, // store data under be mask
    OP_READ  = 1'b1  // load expects one r_valid pulse back
  } tcdm_op_e;

  // outgoing request as it travels through the request fifo
  // field order sets the packing of the 69 bit word
  typedef struct packed {
    logic [`TCDM_AW-1:0] add;  // byte address
    logic [`TCDM_DW-1:0] data; // write data
    logic [`TCDM_BW-1:0] be;   // byte enables
    tcdm_op_e            op;   // read or write
  } tcdm_req_t;

  // returning read data
  // only r_data is kept on the response side
  typedef struct packed {
    logic [`TCDM_DW-1:0] r_data; // load result
  } tcdm_rsp_t;

endpackage : tcdm_fifo_pkg

//--- verilog/stream_fifo.sv
// --------------------
// valid/ready fifo with sync clear and empty flag
// --------------------

`timescale 1ns/1ps

`include "tcdm_fifo_defines.svh"

module stream_fifo #(
  parameter int unsigned DATA_WIDTH = 32 // word width
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,      // drops all stored words

  // push side
  input  logic                  push_valid_i,
  input  logic [DATA_WIDTH-1:0] push_data_i,
  output logic                  push_ready_o, // room for one more word

  // pop side
  output logic                  pop_valid_o,  // at least one word stored
  output logic [DATA_WIDTH-1:0] pop_data_o,
  input  logic                  pop_ready_i,

  output logic                  empty_o
);

  localparam int unsigned DEPTH = `TCDM_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1); // must also hold DEPTH itself

  logic [DATA_WIDTH-1:0] mem_q [DEPTH]; // storage array
  logic [PTR_W-1:0]      wr_ptr_q;      // next slot to write
  logic [PTR_W-1:0]      rd_ptr_q;      // oldest stored word
  logic [CNT_W-1:0]      count_q;       // occupancy

  logic full;
  logic empty;
  logic do_push;
  logic do_pop;

  // flags from occupancy
  assign full  = (count_q == CNT_W'(DEPTH));
  assign empty = (count_q == '0);

  assign push_ready_o = ~full;
  assign pop_valid_o  = ~empty;
  assign empty_o      = empty;

  // handshakes
  assign do_push = push_valid_i & ~full;
  assign do_pop  = pop_ready_i & ~empty;

  // head of queue comes straight from the array
  // a fresh word is visible one edge after its push
  assign pop_data_o = mem_q[rd_ptr_q];

  // write pointer with wrap at DEPTH
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
    end else if (do_push) begin
      wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
    end
  end

  // read pointer with wrap at DEPTH
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
    end else if (clear_i) begin
      rd_ptr_q <= '0;
    end else if (do_pop) begin
      rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
    end
  end

  // occupancy
  // push and pop together leave it unchanged
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1; // push only
        2'b01:   count_q <= count_q - 1'b1; // pop only
        default: count_q <= count_q;        // idle or both
      endcase
    end
  end

  // data array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule : stream_fifo

//--- verilog/rsp_hold_buffer.sv
// --------------------
// one entry hold for memory read responses
// --------------------

`timescale 1ns/1ps

module rsp_hold_buffer
  import tcdm_fifo_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,      // drops a held response

  // memory side never stalls
  input  logic      mem_r_valid_i,
  input  tcdm_rsp_t mem_r_data_i,

  // towards the response fifo push port
  output logic      push_valid_o,
  output tcdm_rsp_t push_data_o,
  input  logic      push_ready_i  // fifo has room
);

  logic      pending_q; // held response not yet accepted
  tcdm_rsp_t held_q;    // last response seen on the memory side

  // live response goes out in its own cycle
  // otherwise the held one is offered again
  assign push_valid_o = mem_r_valid_i | pending_q;
  assign push_data_o  = mem_r_valid_i ? mem_r_data_i : held_q;

  // pending flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (clear_i) begin
      pending_q <= 1'b0;
    end else if (mem_r_valid_i) begin
      // new arrival replaces any held word
      pending_q <= ~push_ready_i; // keep it only if refused
    end else if (push_ready_i) begin
      pending_q <= 1'b0;          // held word went into the fifo
    end
  end

  // capture every arriving response
  // only meaningful while pending_q is set
  always_ff @(posedge clk_i) begin
    if (mem_r_valid_i) begin
      held_q <= mem_r_data_i;
    end
  end

endmodule : rsp_hold_buffer

//--- verilog/tcdm_fifo_top.sv
// --------------------
// tcdm decoupling queue top
// request fifo, response fifo and response hold buffer
// --------------------

`timescale 1ns/1ps

module tcdm_fifo_top
  import tcdm_fifo_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,         // sync flush of both fifos and hold

  // target side towards the core
  input  logic      tgt_req_i,       // level request
  input  tcdm_req_t tgt_req_data_i,
  output logic      tgt_gnt_o,       // low when request fifo full
  output logic      tgt_r_valid_o,
  output tcdm_rsp_t tgt_r_data_o,
  input  logic      tgt_r_ready_i,

  // initiator side towards memory
  output logic      ini_req_o,
  output tcdm_req_t ini_req_data_o,
  input  logic      ini_gnt_i,
  input  logic      ini_r_valid_i,   // one pulse per granted read
  input  tcdm_rsp_t ini_r_data_i,
  output logic      ini_r_ready_o,   // room on the response path

  output logic      empty_o          // both fifos drained
);

  localparam int unsigned REQ_W = $bits(tcdm_req_t); // 69 bits
  localparam int unsigned RSP_W = $bits(tcdm_rsp_t); // 32 bits

  // request path
  logic             req_pop_valid;
  logic             req_pop_ready;
  logic [REQ_W-1:0] req_pop_data;
  logic             req_empty;

  // response path
  logic             rsp_room;       // response fifo not full
  logic             rsp_push_valid;
  tcdm_rsp_t        rsp_push_data;
  logic [RSP_W-1:0] rsp_pop_data;
  logic             rsp_empty;

  // outgoing stream
  // core req/gnt map on push valid/ready
  stream_fifo #(
    .DATA_WIDTH ( REQ_W )
  ) u_req_fifo (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .push_valid_i ( tgt_req_i      ),
    .push_data_i  ( tgt_req_data_i ),
    .push_ready_o ( tgt_gnt_o      ),
    .pop_valid_o  ( req_pop_valid  ),
    .pop_data_o   ( req_pop_data   ),
    .pop_ready_i  ( req_pop_ready  ),
    .empty_o      ( req_empty      )
  );

  // new requests only go out while responses have somewhere to land
  // req may drop before a grant when the response fifo fills
  assign ini_req_o      = req_pop_valid & rsp_room;
  assign ini_req_data_o = tcdm_req_t'(req_pop_data);

  // pop only on a real handshake
  // a stray gnt while req is masked must not lose a word
  assign req_pop_ready = ini_gnt_i & rsp_room;

  assign ini_r_ready_o = rsp_room; // memory issues nothing new without room

  // late responses land here when the fifo is full
  rsp_hold_buffer u_rsp_hold (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .clear_i       ( clear_i        ),
    .mem_r_valid_i ( ini_r_valid_i  ),
    .mem_r_data_i  ( ini_r_data_i   ),
    .push_valid_o  ( rsp_push_valid ),
    .push_data_o   ( rsp_push_data  ),
    .push_ready_i  ( rsp_room       )
  );

  // incoming stream
  // pop side maps on r_valid/r_ready
  stream_fifo #(
    .DATA_WIDTH ( RSP_W )
  ) u_rsp_fifo (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .push_valid_i ( rsp_push_valid ),
    .push_data_i  ( rsp_push_data  ),
    .push_ready_o ( rsp_room       ),
    .pop_valid_o  ( tgt_r_valid_o  ),
    .pop_data_o   ( rsp_pop_data   ),
    .pop_ready_i  ( tgt_r_ready_i  ),
    .empty_o      ( rsp_empty      )
  );

  assign tgt_r_data_o = tcdm_rsp_t'(rsp_pop_data);

  // combined flag
  // a held response is not counted here
  assign empty_o = req_empty & rsp_empty;

endmodule : tcdm_fifo_top

//--- dv/tcdm_fifo_checker.sv
// --------------------
// response checker with reference model and per-test bookkeeping
// --------------------

`timescale 1ns/1ps

module tcdm_fifo_checker
  import tcdm_fifo_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      tgt_req_i,
  input  tcdm_req_t tgt_req_data_i,
  input  logic      tgt_gnt_i,
  input  logic      tgt_r_valid_i,
  input  tcdm_rsp_t tgt_r_data_i,
  input  logic      tgt_r_ready_i,
  output int        pending_o,     // reads granted but not yet answered
  output int        errors_o       // all errors so far
);

  localparam int unsigned WORDS = 64; // same span as the memory model

  logic [31:0] shadow [WORDS];        // last value written per word
  bit          written [WORDS];
  logic [31:0] exp_q [$];             // expected read data in request order
  string       test_name = "reset";
  int          test_errs;
  int          tests_run;
  int          tests_failed;
  int          errors;
  int          pending;

  assign pending_o = pending;
  assign errors_o  = errors;

  // expected read data is the last write to the word or else the address itself
  function automatic logic [31:0] ref_read(input logic [31:0] add);
    int idx;
    idx = int'(add[7:2]);
    if (written[idx]) return shadow[idx];
    return add;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    test_errs++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  // reads are queued at the target grant and popped on r_valid & r_ready
  always @(posedge clk_i) begin : watch
    logic [31:0] exp;
    if (rst_ni && tgt_req_i && tgt_gnt_i) begin
      if (tgt_req_data_i.op == OP_WRITE) begin
        shadow[tgt_req_data_i.add[7:2]]  = tgt_req_data_i.data;
        written[tgt_req_data_i.add[7:2]] = 1'b1;
      end else begin
        exp_q.push_back(ref_read(tgt_req_data_i.add));
      end
    end
    if (rst_ni && tgt_r_valid_i && tgt_r_ready_i) begin
      if (exp_q.size() == 0) begin
        report_error("a response arrived with no read outstanding");
      end else begin
        exp = exp_q.pop_front();
        if (tgt_r_data_i.r_data !== exp) begin
          errors++;
          test_errs++;
          $display("Mismatch in %s: expected %h, actual %h",
                   test_name, exp, tgt_r_data_i.r_data);
        end
      end
    end
    if (rst_ni && clear_i) begin
      exp_q.delete(); // flushed answers never reach the core
    end
    pending = exp_q.size();
  end

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      test_errs++;
      $display("Mismatch in %s (%s): expected %0b, actual %0b", test_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      errors++;
      test_errs++;
      $display("Mismatch in %s (%s): expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (exp_q.size() != 0) report_error("reads were still outstanding at the end of the test");
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, test_errs);
    end
  endtask

  task automatic summary();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
  endtask

endmodule : tcdm_fifo_checker

//--- dv/tcdm_fifo_tb.sv
// --------------------
// testbench top with clock, reset, stimulus, memory model and watchdog
// --------------------

`timescale 1ns/1ps

module tcdm_fifo_tb
  import tcdm_fifo_pkg::*;
();

  localparam int SEED      = 99108;
  localparam int MEM_WORDS = 64;
  localparam int N_DIR     = 8;   // directed write/read pairs
  localparam int N_RAND    = 200; // random requests
  localparam int N_STALL   = 12;  // more reads than response fifo plus hold
  localparam int N_POST    = 4;   // reads before and pairs after the clear
  localparam int N_TOTAL   = 2 * N_DIR + 1 + N_RAND + N_STALL + 3 * N_POST;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      clear;
  logic      tgt_req;
  tcdm_req_t tgt_req_data;
  logic      tgt_gnt;
  logic      tgt_r_valid;
  tcdm_rsp_t tgt_r_data;
  logic      tgt_r_ready;
  logic      ini_req;
  tcdm_req_t ini_req_data;
  logic      ini_gnt;
  logic      ini_r_valid;
  tcdm_rsp_t ini_r_data;
  logic      ini_r_ready;
  logic      empty;
  int        pending;     // from the checker
  int        errors;

  logic [31:0] mem [MEM_WORDS];
  bit          gnt_rand;   // memory grants at random when set
  int          rdy_mode;   // 0 low, 1 high, 2 random
  int          tgt_grants;
  int          mem_grants;

  always #2 clk_i = ~clk_i; // 4 ns period

  tcdm_fifo_top UUT (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .clear_i        ( clear        ),
    .tgt_req_i      ( tgt_req      ),
    .tgt_req_data_i ( tgt_req_data ),
    .tgt_gnt_o      ( tgt_gnt      ),
    .tgt_r_valid_o  ( tgt_r_valid  ),
    .tgt_r_data_o   ( tgt_r_data   ),
    .tgt_r_ready_i  ( tgt_r_ready  ),
    .ini_req_o      ( ini_req      ),
    .ini_req_data_o ( ini_req_data ),
    .ini_gnt_i      ( ini_gnt      ),
    .ini_r_valid_i  ( ini_r_valid  ),
    .ini_r_data_i   ( ini_r_data   ),
    .ini_r_ready_o  ( ini_r_ready  ),
    .empty_o        ( empty        )
  );

  tcdm_fifo_checker u_chk (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .clear_i        ( clear        ),
    .tgt_req_i      ( tgt_req      ),
    .tgt_req_data_i ( tgt_req_data ),
    .tgt_gnt_i      ( tgt_gnt      ),
    .tgt_r_valid_i  ( tgt_r_valid  ),
    .tgt_r_data_i   ( tgt_r_data   ),
    .tgt_r_ready_i  ( tgt_r_ready  ),
    .pending_o      ( pending      ),
    .errors_o       ( errors       )
  );

  // memory model answers a granted read one cycle later
  always @(posedge clk_i) begin : mem_model
    logic      hs;
    logic      nxt_gnt;
    tcdm_req_t rq;
    hs      = rst_ni && ini_req && ini_gnt;  // handshake at this edge
    rq      = ini_req_data;
    nxt_gnt = gnt_rand ? ($urandom_range(3) != 0) : 1'b1;
    #1;
    ini_r_valid = 1'b0;
    if (hs) begin
      mem_grants++;
      if (rq.op == OP_WRITE) begin
        mem[rq.add[7:2]] = rq.data;
      end else begin
        ini_r_valid       = 1'b1;
        ini_r_data.r_data = mem[rq.add[7:2]];
      end
    end
    ini_gnt = nxt_gnt;
  end

  // core side response ready
  always @(posedge clk_i) begin : rdy_drive
    logic nxt_rdy;
    case (rdy_mode)
      0:       nxt_rdy = 1'b0;
      1:       nxt_rdy = 1'b1;
      default: nxt_rdy = ($urandom_range(1) == 1);
    endcase
    #1;
    tgt_r_ready = nxt_rdy;
  end

  task automatic step(input int n);
    repeat (n) @(posedge clk_i);
    #1; // inputs move 1 ns after the edge
  endtask

  // one core request held until granted
  task automatic issue(input tcdm_op_e op, input logic [31:0] add, input logic [31:0] data);
    tgt_req      = 1'b1;
    tgt_req_data = '{add: add, data: data, be: 4'hF, op: op};
    do begin
      @(posedge clk_i);
    end while (!tgt_gnt);
    tgt_grants++;
    #1;
    tgt_req = 1'b0;
  endtask

  function automatic logic [31:0] rand_addr();
    return 32'($urandom_range(MEM_WORDS - 1)) * 4; // word aligned
  endfunction

  // wait until both fifos are drained and every read has come back
  task automatic drain();
    do begin
      step(1);
    end while (!(empty && pending == 0));
    step(2);
    u_chk.check_count("requests reaching memory", tgt_grants, mem_grants);
  endtask

  initial begin : main
    int       i;
    int       gap;
    tcdm_op_e op;
    void'($urandom(SEED));
    rst_ni       = 1'b0;
    clear        = 1'b0;
    tgt_req      = 1'b0;
    tgt_req_data = '0;
    tgt_r_ready  = 1'b0;
    ini_gnt      = 1'b0;
    ini_r_valid  = 1'b0;
    ini_r_data   = '0;
    gnt_rand     = 1'b0;
    rdy_mode     = 1;
    tgt_grants   = 0;
    mem_grants   = 0;
    for (i = 0; i < MEM_WORDS; i++) mem[i] = 32'(i * 4); // each word holds its address
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    u_chk.begin_test("reset_state");
    u_chk.check_bit("empty_o", 1'b1, empty);
    u_chk.check_bit("tgt_gnt_o", 1'b1, tgt_gnt);
    u_chk.check_bit("tgt_r_valid_o", 1'b0, tgt_r_valid);
    u_chk.check_bit("ini_r_ready_o", 1'b1, ini_r_ready);
    step(4);
    u_chk.check_bit("ini_req_o", 1'b0, ini_req);
    u_chk.end_test();

    u_chk.begin_test("write_then_read");
    for (i = 0; i < N_DIR; i++) issue(OP_WRITE, 32'(i * 8), $urandom());
    for (i = 0; i < N_DIR; i++) issue(OP_READ, 32'(i * 8), '0);
    issue(OP_READ, 32'd252, '0); // never written
    drain();
    u_chk.end_test();

    u_chk.begin_test("random_traffic");
    gnt_rand = 1'b1;
    rdy_mode = 2;
    for (i = 0; i < N_RAND; i++) begin
      op = ($urandom_range(1) == 1) ? OP_READ : OP_WRITE;
      issue(op, rand_addr(), $urandom());
      gap = $urandom_range(2);
      if (gap > 0) step(gap);
    end
    drain();
    gnt_rand = 1'b0;
    rdy_mode = 1;
    u_chk.end_test();

    u_chk.begin_test("stalled_responses");
    rdy_mode = 0;
    step(1);
    for (i = 0; i < N_STALL; i++) issue(OP_READ, rand_addr(), '0);
    while (ini_r_ready) step(1); // response fifo full
    step(2);                     // last read in flight lands in the hold
    for (i = 0; i < 16; i++) begin
      u_chk.check_bit("ini_req_o while stalled", 1'b0, ini_req);
      u_chk.check_bit("ini_r_ready_o while stalled", 1'b0, ini_r_ready);
      step(1);
    end
    u_chk.check_bit("tgt_r_valid_o while stalled", 1'b1, tgt_r_valid);
    rdy_mode = 1;
    drain();
    u_chk.end_test();

    u_chk.begin_test("clear_when_idle");
    rdy_mode = 0;
    step(1);
    for (i = 0; i < N_POST; i++) issue(OP_READ, 32'(i * 4 + 128), '0);
    while (mem_grants != tgt_grants) step(1); // every read reached memory
    step(2);                                  // answers sit in the response fifo
    u_chk.check_bit("tgt_r_valid_o before clear", 1'b1, tgt_r_valid);
    u_chk.check_bit("empty_o before clear", 1'b0, empty);
    clear = 1'b1;
    step(1);
    clear = 1'b0;
    step(1);
    u_chk.check_bit("empty_o after clear", 1'b1, empty);
    u_chk.check_bit("tgt_r_valid_o after clear", 1'b0, tgt_r_valid);
    u_chk.check_bit("tgt_gnt_o after clear", 1'b1, tgt_gnt);
    u_chk.check_bit("ini_req_o after clear", 1'b0, ini_req);
    rdy_mode = 1;
    for (i = 0; i < N_POST; i++) issue(OP_WRITE, 32'(i * 4 + 128), $urandom());
    for (i = 0; i < N_POST; i++) issue(OP_READ, 32'(i * 4 + 128), '0);
    drain();
    u_chk.end_test();

    u_chk.summary();
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // budget of 40 cycles per transaction
  initial begin : watchdog
    repeat (N_TOTAL * 40) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", N_TOTAL * 40);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule : tcdm_fifo_tb

//--- src.f
+incdir+include
verilog/tcdm_fifo_pkg.sv
verilog/stream_fifo.sv
verilog/rsp_hold_buffer.sv
verilog/tcdm_fifo_top.sv
dv/tcdm_fifo_checker.sv
dv/tcdm_fifo_tb.sv

//--- Bender.yml
package:
  name: tcdm_fifo

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/tcdm_fifo_pkg.sv
      - verilog/stream_fifo.sv
      - verilog/rsp_hold_buffer.sv
      - verilog/tcdm_fifo_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tcdm_fifo_checker.sv
      - dv/tcdm_fifo_tb.sv
